//--- mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// Data and address width
`define MIPS_XLEN 32

// Architectural register count
`define MIPS_NREGS 32

// First fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

// Handler address for overflow and undefined instructions
`define MIPS_EXC_VECTOR 32'h0000_0080

// Stack pointer register and its reset value
`define MIPS_SP_INDEX 29
`define MIPS_STACK_TOP 32'h0000_0FFC

`endif

//--- mips_pkg.sv
package mips_pkg;

    // Primary opcodes, IR[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_ADDI  = 6'h08,
        OP_ADDIU = 6'h09,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_t;

    // R-type function field, IR[5:0]
    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24
    } funct_t;

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_AND = 2'd2
    } alu_op_t;

    typedef enum logic [3:0] {
        ST_FETCH     = 4'd0,
        ST_DECODE    = 4'd1,
        ST_EXEC_R    = 4'd2,
        ST_EXEC_I    = 4'd3,
        ST_ADDR      = 4'd4,
        ST_MEM_READ  = 4'd5,
        ST_MEM_WRITE = 4'd6,
        ST_WB_ALU    = 4'd7,
        ST_WB_MEM    = 4'd8,
        ST_EXCEPT    = 4'd9
    } ctrl_state_t;

    typedef enum logic [1:0] {
        SRC_B_REG  = 2'd0,
        SRC_B_FOUR = 2'd1,
        SRC_B_IMM  = 2'd2
    } alu_src_b_t;

    typedef enum logic {
        DST_RT = 1'b0,
        DST_RD = 1'b1
    } reg_dst_t;

endpackage

//--- ctrl_if.sv
interface ctrl_if import mips_pkg::*; ();

    // Register write strobes
    logic pc_write;
    logic ir_write;
    logic ab_write;
    logic alu_out_write;
    logic mdr_write;
    logic reg_write;

    // Source selects
    logic       pc_from_vector;
    logic       addr_from_alu;
    logic       mem_to_reg;
    logic       alu_src_a_reg;
    alu_src_b_t alu_src_b;
    alu_op_t    alu_op;
    reg_dst_t   reg_dst;

    // Decode fields and ALU status back to the controller
    opcode_t opcode;
    funct_t  funct;
    logic    overflow;

    modport ctrl (
        output pc_write, ir_write, ab_write, alu_out_write, mdr_write, reg_write,
        output pc_from_vector, addr_from_alu, mem_to_reg,
        output alu_src_a_reg, alu_src_b, alu_op, reg_dst,
        input  opcode, funct, overflow
    );

    modport dp (
        input  pc_write, ir_write, ab_write, alu_out_write, mdr_write, reg_write,
        input  pc_from_vector, addr_from_alu, mem_to_reg,
        input  alu_src_a_reg, alu_src_b, alu_op, reg_dst,
        output opcode, funct, overflow
    );

endinterface

//--- alu.sv
`include "mips_cfg.svh"

module alu
    import mips_pkg::*;
(
    input  logic [`MIPS_XLEN-1:0] a,
    input  logic [`MIPS_XLEN-1:0] b,
    input  alu_op_t               op,
    output logic [`MIPS_XLEN-1:0] result,
    output logic                  overflow
);

    localparam int MSB = `MIPS_XLEN - 1;

    always_comb begin
        overflow = 1'b0;
        case (op)
            ALU_ADD: begin
                result = a + b;
                // Same-sign operands giving an opposite-sign sum
                overflow = (a[MSB] == b[MSB]) && (result[MSB] != a[MSB]);
            end
            ALU_SUB: begin
                result = a - b;
                overflow = (a[MSB] != b[MSB]) && (result[MSB] != a[MSB]);
            end
            ALU_AND: begin
                result = a & b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

//--- reg_file.sv
`include "mips_cfg.svh"

module reg_file (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [$clog2(`MIPS_NREGS)-1:0] rs_addr,
    input  logic [$clog2(`MIPS_NREGS)-1:0] rt_addr,
    input  logic [$clog2(`MIPS_NREGS)-1:0] wr_addr,
    input  logic                          wr_en,
    input  logic [`MIPS_XLEN-1:0]          wr_data,
    output logic [`MIPS_XLEN-1:0]          rs_data,
    output logic [`MIPS_XLEN-1:0]          rt_data
);

    logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];

    // $zero ignores writes and always reads zero
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_NREGS; i++) begin
                regs[i] <= '0;
            end
            regs[`MIPS_SP_INDEX] <= `MIPS_STACK_TOP;
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

//--- datapath.sv
`include "mips_cfg.svh"

module datapath
    import mips_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    ctrl_if.dp                    ctl,
    output logic [`MIPS_XLEN-1:0] wb_adr,
    output logic [`MIPS_XLEN-1:0] wb_dat_w,
    input  logic [`MIPS_XLEN-1:0] wb_dat_r
);

    logic [`MIPS_XLEN-1:0] pc;
    logic [`MIPS_XLEN-1:0] ir;
    logic [`MIPS_XLEN-1:0] a_q;
    logic [`MIPS_XLEN-1:0] b_q;
    logic [`MIPS_XLEN-1:0] alu_out;
    logic [`MIPS_XLEN-1:0] mdr;

    logic [`MIPS_XLEN-1:0] rs_data;
    logic [`MIPS_XLEN-1:0] rt_data;
    logic [`MIPS_XLEN-1:0] imm_ext;
    logic [`MIPS_XLEN-1:0] alu_a;
    logic [`MIPS_XLEN-1:0] alu_b;
    logic [`MIPS_XLEN-1:0] alu_result;
    logic [`MIPS_XLEN-1:0] pc_next;
    logic [`MIPS_XLEN-1:0] wr_data;
    logic [4:0]            wr_addr;

    assign ctl.opcode = opcode_t'(ir[31:26]);
    assign ctl.funct  = funct_t'(ir[5:0]);

    assign imm_ext = {{(`MIPS_XLEN-16){ir[15]}}, ir[15:0]};

    assign alu_a = ctl.alu_src_a_reg ? a_q : pc;

    always_comb begin
        case (ctl.alu_src_b)
            SRC_B_FOUR: alu_b = `MIPS_XLEN'd4;
            SRC_B_IMM:  alu_b = imm_ext;
            default:    alu_b = b_q;
        endcase
    end

    assign wr_addr = (ctl.reg_dst == DST_RD) ? ir[15:11] : ir[20:16];
    assign wr_data = ctl.mem_to_reg ? mdr : alu_out;

    // Exceptions bypass the ALU and jump straight to the handler
    assign pc_next = ctl.pc_from_vector ? `MIPS_EXC_VECTOR : alu_result;

    assign wb_adr   = ctl.addr_from_alu ? alu_out : pc;
    assign wb_dat_w = b_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `MIPS_RESET_PC;
        end else if (ctl.pc_write) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (ctl.ir_write) begin
            ir <= wb_dat_r;
        end
        if (ctl.ab_write) begin
            a_q <= rs_data;
            b_q <= rt_data;
        end
        if (ctl.alu_out_write) begin
            alu_out <= alu_result;
        end
        if (ctl.mdr_write) begin
            mdr <= wb_dat_r;
        end
    end

    reg_file reg_file_inst (
        .clk     (clk),
        .reset   (reset),
        .rs_addr (ir[25:21]),
        .rt_addr (ir[20:16]),
        .wr_addr (wr_addr),
        .wr_en   (ctl.reg_write),
        .wr_data (wr_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    alu alu_inst (
        .a        (alu_a),
        .b        (alu_b),
        .op       (ctl.alu_op),
        .result   (alu_result),
        .overflow (ctl.overflow)
    );

endmodule

//--- control_fsm.sv
module control_fsm
    import mips_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    ctrl_if.ctrl   ctl,
    output logic   wb_cyc,
    output logic   wb_stb,
    output logic   wb_we,
    input  logic   wb_ack
);

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        cyc_q;
    logic        ack_taken;
    logic        funct_ok;

    // An ack only counts while our own request is out
    assign ack_taken = cyc_q && wb_ack;

    assign wb_cyc = cyc_q;
    assign wb_stb = cyc_q;
    assign wb_we  = cyc_q && (state == ST_MEM_WRITE);

    assign funct_ok = ctl.funct inside {FN_ADD, FN_SUB, FN_AND};

    always_comb begin
        state_next         = state;
        ctl.pc_write       = 1'b0;
        ctl.ir_write       = 1'b0;
        ctl.ab_write       = 1'b0;
        ctl.alu_out_write  = 1'b0;
        ctl.mdr_write      = 1'b0;
        ctl.reg_write      = 1'b0;
        ctl.pc_from_vector = 1'b0;
        ctl.addr_from_alu  = 1'b0;
        ctl.mem_to_reg     = 1'b0;
        ctl.alu_src_a_reg  = 1'b0;
        ctl.alu_src_b      = SRC_B_REG;
        ctl.alu_op         = ALU_ADD;
        ctl.reg_dst        = DST_RT;

        case (state)
            ST_FETCH: begin
                // PC + 4 is ready on the ALU while the read is pending
                ctl.alu_src_b = SRC_B_FOUR;
                ctl.pc_write  = ack_taken;
                ctl.ir_write  = ack_taken;
                if (ack_taken) begin
                    state_next = ST_DECODE;
                end
            end
            ST_DECODE: begin
                ctl.ab_write = 1'b1;
                case (ctl.opcode)
                    OP_RTYPE: state_next = funct_ok ? ST_EXEC_R : ST_EXCEPT;
                    OP_ADDI,
                    OP_ADDIU: state_next = ST_EXEC_I;
                    OP_LW,
                    OP_SW:    state_next = ST_ADDR;
                    default:  state_next = ST_EXCEPT;
                endcase
            end
            ST_EXEC_R: begin
                ctl.alu_src_a_reg = 1'b1;
                ctl.alu_out_write = 1'b1;
                case (ctl.funct)
                    FN_SUB:  ctl.alu_op = ALU_SUB;
                    FN_AND:  ctl.alu_op = ALU_AND;
                    default: ctl.alu_op = ALU_ADD;
                endcase
                state_next = ctl.overflow ? ST_EXCEPT : ST_WB_ALU;
            end
            ST_EXEC_I: begin
                ctl.alu_src_a_reg = 1'b1;
                ctl.alu_src_b     = SRC_B_IMM;
                ctl.alu_out_write = 1'b1;
                // addiu wraps silently
                if (ctl.opcode == OP_ADDI && ctl.overflow) begin
                    state_next = ST_EXCEPT;
                end else begin
                    state_next = ST_WB_ALU;
                end
            end
            ST_ADDR: begin
                ctl.alu_src_a_reg = 1'b1;
                ctl.alu_src_b     = SRC_B_IMM;
                ctl.alu_out_write = 1'b1;
                state_next = (ctl.opcode == OP_SW) ? ST_MEM_WRITE : ST_MEM_READ;
            end
            ST_MEM_READ: begin
                ctl.addr_from_alu = 1'b1;
                ctl.mdr_write     = ack_taken;
                if (ack_taken) begin
                    state_next = ST_WB_MEM;
                end
            end
            ST_MEM_WRITE: begin
                ctl.addr_from_alu = 1'b1;
                if (ack_taken) begin
                    state_next = ST_FETCH;
                end
            end
            ST_WB_ALU: begin
                ctl.reg_write = 1'b1;
                ctl.reg_dst   = (ctl.opcode == OP_RTYPE) ? DST_RD : DST_RT;
                state_next    = ST_FETCH;
            end
            ST_WB_MEM: begin
                ctl.reg_write  = 1'b1;
                ctl.mem_to_reg = 1'b1;
                state_next     = ST_FETCH;
            end
            ST_EXCEPT: begin
                ctl.pc_write       = 1'b1;
                ctl.pc_from_vector = 1'b1;
                state_next         = ST_FETCH;
            end
            default: begin
                state_next = ST_FETCH;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_FETCH;
            cyc_q <= 1'b0;
        end else begin
            state <= state_next;
            // Drop after the ack, raise on entry to a bus state
            if (ack_taken) begin
                cyc_q <= 1'b0;
            end else if (state_next inside {ST_FETCH, ST_MEM_READ, ST_MEM_WRITE}) begin
                cyc_q <= 1'b1;
            end
        end
    end

endmodule

//--- mips_core.sv
`include "mips_cfg.svh"

module mips_core (
    input  logic                  clk,
    input  logic                  reset,

    // Wishbone classic master
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic                  wb_we,
    output logic [`MIPS_XLEN-1:0] wb_adr,
    output logic [`MIPS_XLEN-1:0] wb_dat_w,
    input  logic [`MIPS_XLEN-1:0] wb_dat_r,
    input  logic                  wb_ack
);

    ctrl_if ctl_if_inst ();

    // Sequencer and bus request
    control_fsm control_fsm_inst (
        .clk    (clk),
        .reset  (reset),
        .ctl    (ctl_if_inst.ctrl),
        .wb_cyc (wb_cyc),
        .wb_stb (wb_stb),
        .wb_we  (wb_we),
        .wb_ack (wb_ack)
    );

    // Registers, ALU and bus address/data
    datapath datapath_inst (
        .clk      (clk),
        .reset    (reset),
        .ctl      (ctl_if_inst.dp),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r)
    );

endmodule

//--- tb_mips_core.sv
`include "mips_cfg.svh"

module tb_mips_core;

    localparam int          MEM_WORDS = 1024;
    localparam logic [31:0] DATA_BASE = 32'h0000_0400;
    localparam int          WD_MARGIN = 300;

    localparam logic [5:0] OPC_RTYPE = 6'h00;
    localparam logic [5:0] OPC_ADDI  = 6'h08;
    localparam logic [5:0] OPC_ADDIU = 6'h09;
    localparam logic [5:0] OPC_LW    = 6'h23;
    localparam logic [5:0] OPC_SW    = 6'h2b;
    localparam logic [5:0] FUNCT_ADD = 6'h20;
    localparam logic [5:0] FUNCT_SUB = 6'h22;
    localparam logic [5:0] FUNCT_AND = 6'h24;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [`MIPS_XLEN-1:0] wb_adr;
    logic [`MIPS_XLEN-1:0] wb_dat_w;
    logic [`MIPS_XLEN-1:0] wb_dat_r;
    logic                  wb_ack;

    logic [31:0] mem [MEM_WORDS];
    logic        redirect [MEM_WORDS];
    logic [31:0] ref_regs [32];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] build_pc;
    logic [31:0] end_addr;
    logic [31:0] exp_fetch;
    logic [31:0] held_adr;
    logic [31:0] held_dat;
    logic        held_we;
    logic        hold_reset;
    logic        in_req;
    logic        first_req;
    logic        vec_next;
    logic        prog_done;
    int          wait_left;
    int          instr_total;
    int          wd_cycles;
    int          check_count;
    int          error_count;
    int          tests_run;

    mips_core mips_core_inst (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    task automatic check(input logic ok, input string msg);
        check_count++;
        assert (ok) else begin
            error_count++;
            $display("ERROR at %0t: %s", $time, msg);
        end
    endtask

    function automatic logic [31:0] fill_value(input logic [31:0] addr);
        return ~addr ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [31:0] sign_extend(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    // Signed overflow seen in a 33-bit result
    function automatic logic overflows(input logic [31:0] a, input logic [31:0] b,
                                       input logic subtract);
        logic [32:0] wide;
        wide = subtract ? {a[31], a} - {b[31], b} : {a[31], a} + {b[31], b};
        return wide[32] ^ wide[31];
    endfunction

    task automatic place(input logic [31:0] word);
        mem[build_pc[11:2]] = word;
        build_pc = build_pc + 4;
        instr_total++;
    endtask

    task automatic set_reg(input logic [4:0] r, input logic [31:0] value);
        if (r != 5'd0) begin
            ref_regs[r] = value;
        end
    endtask

    // Last instruction traps so the code goes on at the handler
    task automatic trap();
        redirect[build_pc[11:2] - 10'd1] = 1'b1;
        build_pc = `MIPS_EXC_VECTOR;
    endtask

    task automatic i_op(input logic [5:0] op, input logic [4:0] rt, input logic [4:0] rs,
                        input logic [15:0] imm);
        logic [31:0] sum;
        sum = ref_regs[rs] + sign_extend(imm);
        place({op, rs, rt, imm});
        case (op)
            OPC_ADDI: begin
                if (overflows(ref_regs[rs], sign_extend(imm), 1'b0)) begin
                    trap();
                end else begin
                    set_reg(rt, sum);
                end
            end
            OPC_ADDIU: set_reg(rt, sum);
            OPC_LW:    set_reg(rt, mem[sum[11:2]]);
            OPC_SW: begin
                exp_addr.push_back(sum);
                exp_data.push_back(ref_regs[rt]);
            end
            default:   trap();
        endcase
    endtask

    task automatic r_op(input logic [5:0] funct, input logic [4:0] rd, input logic [4:0] rs,
                        input logic [4:0] rt);
        logic [31:0] a;
        logic [31:0] b;
        a = ref_regs[rs];
        b = ref_regs[rt];
        place({OPC_RTYPE, rs, rt, rd, 5'd0, funct});
        if (funct == FUNCT_ADD && !overflows(a, b, 1'b0)) begin
            set_reg(rd, a + b);
        end else if (funct == FUNCT_SUB && !overflows(a, b, 1'b1)) begin
            set_reg(rd, a - b);
        end else if (funct == FUNCT_AND) begin
            set_reg(rd, a & b);
        end else begin
            trap();
        end
    endtask

    task automatic build_program(input int sel);
        int i;
        for (i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_value(i * 4);
            redirect[i] = 1'b0;
        end
        for (i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        ref_regs[`MIPS_SP_INDEX] = `MIPS_STACK_TOP;
        exp_addr.delete();
        exp_data.delete();
        build_pc  = `MIPS_RESET_PC;
        exp_fetch = `MIPS_RESET_PC;
        first_req = 1'b1;
        vec_next  = 1'b0;
        prog_done = 1'b0;
        mem['h600 / 4] = 32'h7fff_fff0;
        mem['h604 / 4] = 32'h0000_0100;
        case (sel)
            0: begin
                i_op(OPC_ADDI, 8, 0, 16'd100);
                i_op(OPC_ADDI, 9, 0, 16'hfff9);
                r_op(FUNCT_ADD, 10, 8, 9);
                r_op(FUNCT_SUB, 11, 9, 8);
                r_op(FUNCT_AND, 12, 8, 9);
                i_op(OPC_ADDIU, 13, 9, 16'h1234);
                i_op(OPC_ADDIU, 14, 8, 16'hff00);
                // Stack pointer still holds its reset value here
                i_op(OPC_SW, 29, 0, 16'h0400);
                i_op(OPC_SW, 10, 0, 16'h0404);
                i_op(OPC_SW, 11, 0, 16'h0408);
                i_op(OPC_SW, 12, 0, 16'h040c);
                i_op(OPC_SW, 13, 0, 16'h0410);
                i_op(OPC_SW, 14, 0, 16'h0414);
                i_op(OPC_SW, 0, 0, 16'h0418);
                i_op(OPC_ADDI, 16, 0, 16'h0500);
                i_op(OPC_LW, 15, 16, 16'h0008);
                i_op(OPC_SW, 15, 29, 16'hfffc);
            end
            1: begin
                i_op(OPC_LW, 8, 0, 16'h0600);
                i_op(OPC_ADDI, 10, 0, 16'd55);
                i_op(OPC_ADDIU, 9, 8, 16'h0020);
                i_op(OPC_SW, 9, 0, 16'h0400);
                i_op(OPC_ADDI, 10, 8, 16'h0020);
                i_op(OPC_SW, 10, 0, 16'h0404);
            end
            2: begin
                i_op(OPC_LW, 8, 0, 16'h0600);
                i_op(OPC_LW, 9, 0, 16'h0604);
                i_op(OPC_ADDI, 10, 0, 16'hfffd);
                r_op(FUNCT_ADD, 10, 8, 9);
                i_op(OPC_SW, 10, 0, 16'h0400);
            end
            3: begin
                i_op(OPC_ADDI, 8, 0, 16'd9);
                i_op(6'h3f, 8, 0, 16'h0000);
                i_op(OPC_SW, 8, 0, 16'h0400);
            end
            default: begin
                i_op(OPC_ADDI, 8, 0, 16'd12);
                r_op(6'h25, 8, 8, 8);
                i_op(OPC_SW, 8, 0, 16'h0400);
            end
        endcase
        end_addr = build_pc;
    endtask

    task automatic open_request();
        if (vec_next) begin
            check(!wb_we && wb_adr == `MIPS_EXC_VECTOR,
                  $sformatf("access at %h after a trap, expected read at vector", wb_adr));
            vec_next = 1'b0;
        end
        if (first_req) begin
            check(!wb_we && wb_adr == `MIPS_RESET_PC,
                  $sformatf("first bus cycle at %h we=%b, expected read at reset PC",
                            wb_adr, wb_we));
            first_req = 1'b0;
        end
        check(wb_adr < MEM_WORDS * 4, $sformatf("address %h outside memory", wb_adr));
        // Reads below the data area are instruction fetches
        if (!wb_we && wb_adr < DATA_BASE) begin
            check(wb_adr == exp_fetch, $sformatf("fetch at %h, expected %h", wb_adr, exp_fetch));
            if (wb_adr == end_addr) begin
                prog_done = 1'b1;
            end else begin
                vec_next  = redirect[wb_adr[11:2]];
                exp_fetch = vec_next ? `MIPS_EXC_VECTOR : wb_adr + 4;
            end
        end
    endtask

    task automatic finish_request();
        logic [31:0] want_addr;
        logic [31:0] want_data;
        if (held_we) begin
            mem[held_adr[11:2]] = held_dat;
            if (exp_addr.size() == 0) begin
                check(1'b0, $sformatf("store of %h to %h was not expected", held_dat, held_adr));
            end else begin
                want_addr = exp_addr.pop_front();
                want_data = exp_data.pop_front();
                check(held_adr == want_addr && held_dat == want_data,
                      $sformatf("store %h to %h, expected %h to %h",
                                held_dat, held_adr, want_data, want_addr));
            end
        end else begin
            wb_dat_r = mem[held_adr[11:2]];
        end
        wb_ack = 1'b1;
    endtask

    task automatic serve_bus();
        if (wb_ack) begin
            wb_ack = 1'b0;
            in_req = 1'b0;
            check(!wb_cyc && !wb_stb, "cyc or stb still high in the cycle after ack");
        end else if (wb_cyc && wb_stb) begin
            if (!in_req) begin
                in_req    = 1'b1;
                held_adr  = wb_adr;
                held_we   = wb_we;
                held_dat  = wb_dat_w;
                wait_left = $urandom % 4;
                open_request();
            end else begin
                check(wb_adr == held_adr && wb_we == held_we && wb_dat_w == held_dat,
                      $sformatf("bus signals changed while waiting for ack at %h", held_adr));
            end
            if (!prog_done) begin
                if (wait_left == 0) begin
                    finish_request();
                end else begin
                    wait_left--;
                end
            end
        end
    endtask

    // Wishbone slave and reset driver on the falling edge
    initial begin
        void'($urandom(32'h8dcf_9e71));
        forever begin
            @(negedge clk);
            if (reset) begin
                check(!wb_cyc && !wb_stb && !wb_we,
                      $sformatf("bus active in reset: cyc=%b stb=%b we=%b",
                                wb_cyc, wb_stb, wb_we));
            end
            reset = hold_reset;
            if (reset) begin
                wb_ack = 1'b0;
                in_req = 1'b0;
            end else begin
                serve_bus();
            end
        end
    end

    task automatic run_test(input int sel, input string name);
        int checks_before;
        int errors_before;
        checks_before = check_count;
        errors_before = error_count;
        @(posedge clk);
        hold_reset = 1'b1;
        build_program(sel);
        repeat (10) @(posedge clk);
        hold_reset = 1'b0;
        wait (prog_done);
        check(exp_addr.size() == 0,
              $sformatf("%0d expected stores never happened", exp_addr.size()));
        tests_run++;
        $display("Test %0d %s: %0d checks, %0d errors", tests_run, name,
                 check_count - checks_before, error_count - errors_before);
    endtask

    initial begin
        wd_cycles = 0;
        while (wd_cycles <= instr_total * 20 + WD_MARGIN) begin
            @(posedge clk);
            wd_cycles++;
        end
        $display("Watchdog expired after %0d cycles with the program unfinished", wd_cycles);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        reset       = 1'b1;
        hold_reset  = 1'b1;
        wb_ack      = 1'b0;
        wb_dat_r    = '0;
        in_req      = 1'b0;
        prog_done   = 1'b0;
        instr_total = 0;
        check_count = 0;
        error_count = 0;
        tests_run   = 0;
        run_test(0, "alu_and_memory");
        run_test(1, "addi_overflow");
        run_test(2, "add_overflow");
        run_test(3, "undefined_opcode");
        run_test(4, "undefined_funct");
        $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+.
mips_pkg.sv
ctrl_if.sv
alu.sv
reg_file.sv
datapath.sv
control_fsm.sv
mips_core.sv
tb_mips_core.sv

//--- Bender.yml
package:
  name: mips_core

export_include_dirs:
  - .

sources:
  - mips_pkg.sv
  - ctrl_if.sv
  - alu.sv
  - reg_file.sv
  - datapath.sv
  - control_fsm.sv
  - mips_core.sv
  - target: test
    files:
      - tb_mips_core.sv
